// File: design/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ======================================================================
// cache geometry
// ======================================================================
`define DC_ADDR_W  32
`define DC_WAYS    2
`define DC_SETS    16
`define DC_IDX_W   4
`define DC_WORDS   4
`define DC_OFS_W   4
`define DC_TAG_W   24
`define DC_LINE_W  128

// address field positions
`define DC_IDX_LSB `DC_OFS_W
`define DC_TAG_LSB (`DC_OFS_W + `DC_IDX_W)

// size and extension codes on the request port
`define DC_SZ_B    3'd0
`define DC_SZ_H    3'd1
`define DC_SZ_W    3'd2
`define DC_SZ_BU   3'd4
`define DC_SZ_HU   3'd5

`endif

// File: design/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

  // one cache line, seen as words or as bytes
  // byte 0 and word 0 sit at the low end (little endian)
  typedef union packed {
    logic [`DC_WORDS-1:0][31:0]     words;
    logic [`DC_LINE_W/8-1:0][7:0]   bytes;
  } dcache_line_u;

endpackage

// File: design/dcache_tag_array.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tag_array (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`DC_IDX_W-1:0] idx_i,
  input  logic [`DC_TAG_W-1:0] tag_i,
  input  logic                 touch_i,
  input  logic                 hit_way_wr_dirty_i,
  input  logic                 fill_i,
  input  logic                 fill_dirty_i,
  output logic                 hit_o,
  output logic                 hit_way_o,
  output logic                 victim_way_o,
  output logic                 victim_dirty_o,
  output logic [`DC_TAG_W-1:0] victim_tag_o
);

  logic [`DC_TAG_W-1:0]                tag_q [`DC_WAYS][`DC_SETS];
  logic [`DC_WAYS-1:0][`DC_SETS-1:0]   valid_q;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0]   dirty_q;
  logic [`DC_SETS-1:0]                 lru_q;
  logic [`DC_WAYS-1:0]                 match;
  logic                                used_way;

  // ======================================================================
  // lookup
  // ======================================================================
  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      match[w] = valid_q[w][idx_i] && (tag_q[w][idx_i] == tag_i);
    end
  end

  assign hit_o     = |match;
  assign hit_way_o = match[1];

  // lru bit points at the way to replace next
  assign victim_way_o   = lru_q[idx_i];
  assign victim_dirty_o = valid_q[victim_way_o][idx_i] && dirty_q[victim_way_o][idx_i];
  assign victim_tag_o   = tag_q[victim_way_o][idx_i];

  // a fill lands in the victim way, so it counts as the used way
  assign used_way = hit_o ? hit_way_o : victim_way_o;

  // ======================================================================
  // state update
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (touch_i) begin
        lru_q[idx_i] <= ~used_way;
      end
      if (fill_i) begin
        valid_q[victim_way_o][idx_i] <= 1'b1;
        dirty_q[victim_way_o][idx_i] <= fill_dirty_i;
      end else if (hit_way_wr_dirty_i) begin
        dirty_q[hit_way_o][idx_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i) begin
      tag_q[victim_way_o][idx_i] <= tag_i;
    end
  end

endmodule

// File: design/dcache_data_array.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_data_array
  import dcache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`DC_IDX_W-1:0] idx_i,
  input  logic                 rd_way_i,
  input  logic                 wr_i,
  input  logic                 wr_way_i,
  input  dcache_line_u         line_i,
  input  logic                 merge_i,
  input  logic [`DC_OFS_W-1:0] ofs_i,
  input  logic [2:0]           size_i,
  input  logic [31:0]          wdata_i,
  output dcache_line_u         line_o
);

  dcache_line_u mem_q [`DC_WAYS][`DC_SETS];
  dcache_line_u wr_line;
  logic [31:0]  st_lanes;
  logic [3:0]   st_be;

  assign line_o = mem_q[rd_way_i][idx_i];

  // store data replicated over the lanes, byte enables from offset
  always_comb begin
    case (size_i)
      `DC_SZ_B, `DC_SZ_BU: begin
        st_lanes = {4{wdata_i[7:0]}};
        st_be    = 4'b0001 << ofs_i[1:0];
      end
      `DC_SZ_H, `DC_SZ_HU: begin
        st_lanes = {2{wdata_i[15:0]}};
        st_be    = ofs_i[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        st_lanes = wdata_i;
        st_be    = 4'b1111;
      end
    endcase
    wr_line = line_i;
    for (int b = 0; b < 4; b++) begin
      if (merge_i && st_be[b]) begin
        wr_line.bytes[{ofs_i[3:2], 2'(b)}] = st_lanes[8*b +: 8];
      end
    end
  end

  // no array writes while reset is held
  always_ff @(posedge clk) begin
    if (rst_n && wr_i) begin
      mem_q[wr_way_i][idx_i] <= wr_line;
    end
  end

endmodule

// File: design/dcache_miss_fsm.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_miss_fsm
  import dcache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  logic                  victim_dirty_i,
  input  logic [`DC_TAG_W-1:0]  victim_tag_i,
  input  logic [`DC_ADDR_W-1:0] addr_i,
  input  dcache_line_u          victim_line_i,
  input  logic                  mem_req_ready_i,
  input  logic                  mem_wready_i,
  input  logic                  mem_rvalid_i,
  input  logic [31:0]           mem_rdata_i,
  output logic                  mem_req_valid_o,
  output logic                  mem_req_we_o,
  output logic [`DC_ADDR_W-1:0] mem_req_addr_o,
  output logic                  mem_wvalid_o,
  output logic [31:0]           mem_wdata_o,
  output logic                  mem_wlast_o,
  output dcache_line_u          refill_line_o,
  output logic                  fill_o,
  output logic                  busy_o
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_WB_REQ  = 3'd1;
  localparam logic [2:0] S_WB_DATA = 3'd2;
  localparam logic [2:0] S_RD_REQ  = 3'd3;
  localparam logic [2:0] S_REFILL  = 3'd4;
  localparam logic [2:0] S_DONE    = 3'd5;

  localparam int BEAT_W = $clog2(`DC_WORDS);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DC_WORDS - 1);

  logic [2:0]            state_q;
  logic [BEAT_W-1:0]     wcnt_q;
  logic [BEAT_W-1:0]     rcnt_q;
  dcache_line_u          wb_line_q;
  logic [`DC_ADDR_W-1:0] wb_addr_q;
  dcache_line_u          refill_q;

  // ======================================================================
  // memory side outputs
  // ======================================================================
  assign mem_req_valid_o = (state_q == S_WB_REQ) || (state_q == S_RD_REQ);
  assign mem_req_we_o    = (state_q == S_WB_REQ);
  assign mem_req_addr_o  = mem_req_we_o ? wb_addr_q :
                           {addr_i[`DC_ADDR_W-1:`DC_OFS_W], {`DC_OFS_W{1'b0}}};

  assign mem_wvalid_o = (state_q == S_WB_DATA);
  assign mem_wdata_o  = wb_line_q.words[wcnt_q];
  assign mem_wlast_o  = (wcnt_q == LAST_BEAT);

  assign refill_line_o = refill_q;
  assign fill_o        = (state_q == S_DONE);
  assign busy_o        = (state_q != S_IDLE);

  // ======================================================================
  // sequencing
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      wcnt_q  <= '0;
      rcnt_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // clean victim skips the writeback
          if (start_i) begin
            state_q <= victim_dirty_i ? S_WB_REQ : S_RD_REQ;
          end
        end
        S_WB_REQ: begin
          if (mem_req_ready_i) begin
            state_q <= S_WB_DATA;
          end
        end
        S_WB_DATA: begin
          if (mem_wready_i) begin
            wcnt_q <= wcnt_q + 1'b1;
            if (mem_wlast_o) begin
              state_q <= S_RD_REQ;
            end
          end
        end
        S_RD_REQ: begin
          if (mem_req_ready_i) begin
            state_q <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (mem_rvalid_i) begin
            rcnt_q <= rcnt_q + 1'b1;
            if (rcnt_q == LAST_BEAT) begin
              state_q <= S_DONE;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // beat buffers
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && start_i) begin
      wb_line_q <= victim_line_i;
      wb_addr_q <= {victim_tag_i, addr_i[`DC_IDX_LSB +: `DC_IDX_W], {`DC_OFS_W{1'b0}}};
    end
    if (state_q == S_REFILL && mem_rvalid_i) begin
      refill_q.words[rcnt_q] <= mem_rdata_i;
    end
  end

endmodule

// File: design/dcache_load_align.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_load_align
  import dcache_pkg::*;
(
  input  dcache_line_u         line_i,
  input  logic [`DC_OFS_W-1:0] ofs_i,
  input  logic [2:0]           size_i,
  output logic [31:0]          rdata_o
);

  logic [31:0] sel_word;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // word first, then the lane inside it
  assign sel_word = line_i.words[ofs_i[3:2]];
  assign sel_byte = sel_word[8*ofs_i[1:0] +: 8];
  assign sel_half = ofs_i[1] ? sel_word[31:16] : sel_word[15:0];

  always_comb begin
    case (size_i)
      `DC_SZ_B:  rdata_o = {{24{sel_byte[7]}}, sel_byte};
      `DC_SZ_H:  rdata_o = {{16{sel_half[15]}}, sel_half};
      `DC_SZ_BU: rdata_o = {24'd0, sel_byte};
      `DC_SZ_HU: rdata_o = {16'd0, sel_half};
      default:   rdata_o = sel_word;
    endcase
  end

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid_i,
  input  logic                  req_we_i,
  input  logic [2:0]            req_size_i,
  input  logic [`DC_ADDR_W-1:0] req_addr_i,
  input  logic [31:0]           req_wdata_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output logic [31:0]           rsp_rdata_o,
  output logic                  mem_req_valid_o,
  output logic                  mem_req_we_o,
  output logic [`DC_ADDR_W-1:0] mem_req_addr_o,
  input  logic                  mem_req_ready_i,
  output logic                  mem_wvalid_o,
  output logic [31:0]           mem_wdata_o,
  output logic                  mem_wlast_o,
  input  logic                  mem_wready_i,
  input  logic                  mem_rvalid_i,
  input  logic [31:0]           mem_rdata_i
);

  logic                  st_valid_q;
  logic                  st_we_q;
  logic [2:0]            st_size_q;
  logic [`DC_ADDR_W-1:0] st_addr_q;
  logic [31:0]           st_wdata_q;

  logic                  hit;
  logic                  hit_way;
  logic                  victim_way;
  logic                  victim_dirty;
  logic [`DC_TAG_W-1:0]  victim_tag;
  logic                  fill;
  logic                  busy;
  logic                  hit_rsp;
  logic                  miss_start;
  dcache_line_u          rd_line;
  dcache_line_u          refill_line;
  dcache_line_u          wr_src_line;
  dcache_line_u          rsp_line;

  // ======================================================================
  // stage register and handshake
  // ======================================================================
  assign hit_rsp     = st_valid_q & hit & ~busy;
  assign miss_start  = st_valid_q & ~hit & ~busy;
  assign req_ready_o = ~busy & (~st_valid_q | hit);
  // hit answers in the stage cycle, miss in the fsm done cycle
  assign rsp_valid_o = hit_rsp | fill;
  assign wr_src_line = fill ? refill_line : rd_line;
  assign rsp_line    = fill ? refill_line : rd_line;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      st_valid_q <= req_valid_i;
    end else if (fill) begin
      st_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready_o && req_valid_i) begin
      st_we_q    <= req_we_i;
      st_size_q  <= req_size_i;
      st_addr_q  <= req_addr_i;
      st_wdata_q <= req_wdata_i;
    end
  end

  // ======================================================================
  // arrays, miss handler, load path
  // ======================================================================
  dcache_tag_array tag_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .idx_i              (st_addr_q[`DC_IDX_LSB +: `DC_IDX_W]),
    .tag_i              (st_addr_q[`DC_ADDR_W-1:`DC_TAG_LSB]),
    .touch_i            (rsp_valid_o),
    .hit_way_wr_dirty_i (hit_rsp & st_we_q),
    .fill_i             (fill),
    .fill_dirty_i       (st_we_q),
    .hit_o              (hit),
    .hit_way_o          (hit_way),
    .victim_way_o       (victim_way),
    .victim_dirty_o     (victim_dirty),
    .victim_tag_o       (victim_tag)
  );

  dcache_data_array data_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .idx_i    (st_addr_q[`DC_IDX_LSB +: `DC_IDX_W]),
    .rd_way_i (hit ? hit_way : victim_way),
    .wr_i     ((hit_rsp & st_we_q) | fill),
    .wr_way_i (fill ? victim_way : hit_way),
    .line_i   (wr_src_line),
    .merge_i  (st_we_q),
    .ofs_i    (st_addr_q[`DC_OFS_W-1:0]),
    .size_i   (st_size_q),
    .wdata_i  (st_wdata_q),
    .line_o   (rd_line)
  );

  dcache_miss_fsm fsm_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (miss_start),
    .victim_dirty_i  (victim_dirty),
    .victim_tag_i    (victim_tag),
    .addr_i          (st_addr_q),
    .victim_line_i   (rd_line),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_wready_i    (mem_wready_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_wvalid_o    (mem_wvalid_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_wlast_o     (mem_wlast_o),
    .refill_line_o   (refill_line),
    .fill_o          (fill),
    .busy_o          (busy)
  );

  dcache_load_align align_i (
    .line_i  (rsp_line),
    .ofs_i   (st_addr_q[`DC_OFS_W-1:0]),
    .size_i  (st_size_q),
    .rdata_o (rsp_rdata_o)
  );

endmodule

// File: verif/dcache_asserts.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  mem_req_valid_o,
  input logic                  mem_req_ready_i,
  input logic                  mem_req_we_o,
  input logic [`DC_ADDR_W-1:0] mem_req_addr_o,
  input logic                  rsp_valid_o
);

  // request held until the memory takes it
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid_o && !mem_req_ready_i |=>
      mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_we_o))
    else $error("memory request changed before acceptance");

  req_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid_o |-> mem_req_addr_o[`DC_OFS_W-1:0] == '0)
    else $error("memory request address not line aligned");

  // response is a single cycle pulse
  rsp_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |=> !rsp_valid_o)
    else $error("rsp_valid_o high for more than one cycle");

endmodule

bind dcache_top dcache_asserts asserts_i (.*);

// File: verif/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tb;

  localparam int MEM_WORDS = 4096;
  localparam int SEED      = 17;
  // request counts per test, summed for the watchdog
  localparam int N_REQS    = 1 + 1 + 9 + 4 + 6 + 24;
  localparam int WATCHDOG_NS = (N_REQS * 40 + 4) * 8;

  logic        clk;
  logic        rst_n;
  logic        req_valid_i;
  logic        req_we_i;
  logic [2:0]  req_size_i;
  logic [31:0] req_addr_i;
  logic [31:0] req_wdata_i;
  logic        req_ready_o;
  logic        rsp_valid_o;
  logic [31:0] rsp_rdata_o;
  logic        mem_req_valid_o;
  logic        mem_req_we_o;
  logic [31:0] mem_req_addr_o;
  logic        mem_req_ready_i;
  logic        mem_wvalid_o;
  logic [31:0] mem_wdata_o;
  logic        mem_wlast_o;
  logic        mem_wready_i;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;

  int          seed = SEED;
  int          err_count = 0;
  logic [31:0] mem [MEM_WORDS];
  logic [7:0]  ref_mem [MEM_WORDS*4];
  logic [31:0] log_addr [$];
  logic        log_we [$];
  logic [`DC_TAG_W-1:0] ref_tag [2][`DC_SETS];
  logic        ref_valid [2][`DC_SETS];
  logic        ref_dirty [2][`DC_SETS];
  logic        ref_lru [`DC_SETS];
  logic        last_wb;
  logic [31:0] last_wb_addr;

  dcache_top dut_i (.*);

  always #4 clk = ~clk;

  // ======================================================================
  // error reporting
  // ======================================================================
  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    err_count++;
    $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic other_error(input string what);
    err_count++;
    $display("at %0t ns: %s", $time, what);
    $display("Errors found");
    $fatal(1);
  endtask

  function automatic logic [31:0] fill_word(input int a);
    return (a * 32'h0100_0193) ^ 32'hA5C3_0F17 ^ (a << 19);
  endfunction

  function automatic int size_bytes(input logic [2:0] size);
    if (size == `DC_SZ_W) return 4;
    if (size == `DC_SZ_H || size == `DC_SZ_HU) return 2;
    return 1;
  endfunction

  // expected load value from the byte image
  function automatic logic [31:0] load_expect(input logic [31:0] addr, input logic [2:0] size);
    logic [31:0] v;
    v = {ref_mem[addr+3], ref_mem[addr+2], ref_mem[addr+1], ref_mem[addr]};
    case (size)
      `DC_SZ_B:  return {{24{v[7]}}, v[7:0]};
      `DC_SZ_BU: return {24'd0, v[7:0]};
      `DC_SZ_H:  return {{16{v[15]}}, v[15:0]};
      `DC_SZ_HU: return {16'd0, v[15:0]};
      default:   return v;
    endcase
  endfunction

  // ======================================================================
  // memory model
  // ======================================================================
  task automatic serve_mem;
    int          dly;
    int          b;
    logic [31:0] addr;
    logic        we;
    dly = $random(seed) & 3;
    repeat (dly) @(posedge clk);
    @(posedge clk);
    #1 mem_req_ready_i = 1'b1;
    addr = mem_req_addr_o;
    we   = mem_req_we_o;
    @(posedge clk);
    #1 mem_req_ready_i = 1'b0;
    log_addr.push_back(addr);
    log_we.push_back(we);
    b = 0;
    if (we) begin
      while (b < 4) begin
        mem_wready_i = $random(seed) & 1;
        @(negedge clk);
        if (mem_wvalid_o && mem_wready_i) begin
          assert (mem_wlast_o == (b == 3)) else value_error("mem_wlast_o", mem_wlast_o, b == 3);
          mem[(addr[13:0] >> 2) + b] = mem_wdata_o;
          b++;
        end
        @(posedge clk);
        #1;
      end
      mem_wready_i = 1'b0;
    end else begin
      dly = $random(seed) & 3;
      repeat (dly) begin
        @(posedge clk);
        #1;
      end
      for (b = 0; b < 4; b++) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = mem[(addr[13:0] >> 2) + b];
        @(posedge clk);
        #1;
      end
      mem_rvalid_i = 1'b0;
    end
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (mem_req_valid_o) serve_mem();
    end
  end

  // ======================================================================
  // request driver with reference model
  // exp_hit is 0 for a miss, 1 for a hit, 2 for either
  // ======================================================================
  task automatic do_req(input logic we, input logic [2:0] size, input logic [31:0] addr,
                        input logic [31:0] wdata, input int exp_hit);
    logic [3:0]  idx;
    logic [23:0] tag;
    logic        hit;
    logic        way;
    logic [31:0] exp;
    logic        rdy;
    logic        accepted;
    int          lat;
    idx = addr[7:4];
    tag = addr[31:8];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (exp_hit != 2) begin
      assert (hit == exp_hit[0]) else other_error("reference model disagrees with test hit plan");
    end
    last_wb = 1'b0;
    if (!hit) begin
      way          = ref_lru[idx];
      last_wb      = ref_valid[way][idx] && ref_dirty[way][idx];
      last_wb_addr = {ref_tag[way][idx], idx, 4'd0};
      ref_tag[way][idx]   = tag;
      ref_valid[way][idx] = 1'b1;
      ref_dirty[way][idx] = we;
    end else if (we) begin
      ref_dirty[way][idx] = 1'b1;
    end
    ref_lru[idx] = ~way;
    exp = load_expect(addr, size);
    if (we) begin
      for (int i = 0; i < size_bytes(size); i++) ref_mem[addr+i] = wdata[8*i +: 8];
    end
    log_addr.delete();
    log_we.delete();
    @(posedge clk);
    #1;
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_size_i  = size;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      rdy = req_ready_o;
      @(posedge clk);
      accepted = rdy;
    end
    #1 req_valid_i = 1'b0;
    lat = 0;
    rdy = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      lat++;
      rdy = rsp_valid_o;
    end
    if (!we) begin
      assert (rsp_rdata_o == exp) else value_error("rsp_rdata_o", rsp_rdata_o, exp);
    end
    if (hit) begin
      assert (lat == 1) else value_error("hit latency", lat, 1);
      assert (log_addr.size() == 0) else other_error("memory request issued on a hit");
    end else begin
      assert (log_addr.size() == (last_wb ? 2 : 1))
        else value_error("memory request count", log_addr.size(), last_wb ? 2 : 1);
      if (last_wb) begin
        assert (log_we[0] && log_addr[0] == last_wb_addr)
          else value_error("writeback mem_req_addr_o", log_addr[0], last_wb_addr);
        for (int i = 0; i < 16; i += 4) begin
          exp = load_expect(last_wb_addr + i, `DC_SZ_W);
          assert (mem[(last_wb_addr[13:0] + i) >> 2] == exp)
            else value_error("mem_wdata_o", mem[(last_wb_addr[13:0] + i) >> 2], exp);
        end
      end
      assert (!log_we[log_we.size()-1] && log_addr[log_addr.size()-1] == {addr[31:4], 4'd0})
        else value_error("refill mem_req_addr_o", log_addr[log_addr.size()-1], {addr[31:4], 4'd0});
    end
  endtask

  // ======================================================================
  // directed tests
  // ======================================================================
  task automatic test_reset_and_miss;
    assert (req_ready_o && !rsp_valid_o && !mem_req_valid_o)
      else other_error("outputs not at reset values after reset");
    do_req(1'b0, `DC_SZ_W, 32'h0000_0114, 32'd0, 0);
  endtask

  task automatic test_hit;
    do_req(1'b0, `DC_SZ_W, 32'h0000_0118, 32'd0, 1);
  endtask

  task automatic test_store_merge;
    do_req(1'b1, `DC_SZ_B, 32'h0000_0221, 32'h0000_0080, 0);
    do_req(1'b1, `DC_SZ_H, 32'h0000_0226, 32'h0000_8001, 1);
    do_req(1'b1, `DC_SZ_W, 32'h0000_0228, 32'hF00D_BEEF, 1);
    do_req(1'b0, `DC_SZ_B, 32'h0000_0221, 32'd0, 1);
    do_req(1'b0, `DC_SZ_BU, 32'h0000_0221, 32'd0, 1);
    do_req(1'b0, `DC_SZ_H, 32'h0000_0226, 32'd0, 1);
    do_req(1'b0, `DC_SZ_HU, 32'h0000_0226, 32'd0, 1);
    do_req(1'b0, `DC_SZ_W, 32'h0000_0228, 32'd0, 1);
    do_req(1'b0, `DC_SZ_W, 32'h0000_0220, 32'd0, 1);
  endtask

  task automatic test_writeback;
    do_req(1'b0, `DC_SZ_W, 32'h0000_1220, 32'd0, 0);
    do_req(1'b0, `DC_SZ_W, 32'h0000_2220, 32'd0, 0);
    assert (last_wb && last_wb_addr == 32'h0000_0220)
      else other_error("dirty line was not selected for writeback");
    do_req(1'b0, `DC_SZ_W, 32'h0000_0228, 32'd0, 0);
    do_req(1'b0, `DC_SZ_H, 32'h0000_0226, 32'd0, 1);
  endtask

  task automatic test_plru;
    do_req(1'b0, `DC_SZ_W, 32'h0000_0050, 32'd0, 0);
    do_req(1'b0, `DC_SZ_W, 32'h0000_1050, 32'd0, 0);
    do_req(1'b0, `DC_SZ_W, 32'h0000_0054, 32'd0, 1);
    do_req(1'b0, `DC_SZ_W, 32'h0000_2050, 32'd0, 0);
    do_req(1'b0, `DC_SZ_W, 32'h0000_005C, 32'd0, 1);
    do_req(1'b0, `DC_SZ_W, 32'h0000_1058, 32'd0, 0);
  endtask

  // random mix under random memory stalls
  task automatic test_random_stalls;
    logic [2:0]  codes [5];
    logic [2:0]  size;
    logic [31:0] addr;
    codes = '{`DC_SZ_B, `DC_SZ_H, `DC_SZ_W, `DC_SZ_BU, `DC_SZ_HU};
    for (int n = 0; n < 24; n++) begin
      size = codes[($random(seed) & 32'h7fff) % 5];
      addr = {18'd0, 2'($random(seed)), 4'($random(seed)), 4'($random(seed)), 4'd0};
      addr[3:0] = 4'($random(seed)) & ~4'(size_bytes(size) - 1);
      do_req(1'($random(seed)), size, addr, $random(seed), 2);
    end
  endtask

  initial begin
    #WATCHDOG_NS;
    $display("watchdog expired before the tests finished");
    $display("Errors found");
    $fatal(1);
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    req_valid_i = 1'b0;
    req_we_i = 1'b0;
    req_size_i = '0;
    req_addr_i = '0;
    req_wdata_i = '0;
    mem_req_ready_i = 1'b0;
    mem_wready_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = fill_word(a);
      for (int i = 0; i < 4; i++) ref_mem[4*a+i] = mem[a][8*i +: 8];
    end
    for (int s = 0; s < `DC_SETS; s++) begin
      ref_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        ref_valid[w][s] = 1'b0;
        ref_dirty[w][s] = 1'b0;
        ref_tag[w][s] = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    test_reset_and_miss();
    test_hit();
    test_store_merge();
    test_writeback();
    test_plru();
    test_random_stalls();
    repeat (2) @(posedge clk);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+design
design/dcache_pkg.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_miss_fsm.sv
design/dcache_load_align.sv
design/dcache_top.sv
verif/dcache_asserts.sv
verif/dcache_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module dcache_tb

obj_dir/Vdcache_tb: sim.f design/*.sv design/*.svh verif/*.sv
	verilator --binary --timing --assert -f sim.f --top-module dcache_tb -o Vdcache_tb

sim: obj_dir/Vdcache_tb
	-./obj_dir/Vdcache_tb > sim.log 2>&1
	cat sim.log
	@if grep -q "Errors found" sim.log; then \
	  echo "simulation FAILED"; exit 1; \
	elif grep -q "No errors" sim.log; then \
	  echo "simulation passed"; \
	else \
	  echo "simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
